// File: bench/rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions (
    input logic                          clk,
    input logic                          rst_n,
    input logic [rv_pkg::xlen-1:0]       imem_addr,
    input logic [rv_pkg::xlen-1:0]       imem_data,
    input logic                          wb_valid,
    input logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    input logic                          redirect
);

    int                      fail_count = 0;
    logic [rv_pkg::xlen-1:0] prev_addr;
    logic [rv_pkg::xlen-1:0] prev_data;
    logic [rv_pkg::xlen-1:0] b_off;
    logic [rv_pkg::xlen-1:0] fix_target;

    // the branch that mispredicts was fetched one cycle before its redirect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_addr <= '0;
            prev_data <= '0;
        end else begin
            prev_addr <= imem_addr;
            prev_data <= imem_data;
        end
    end

    assign b_off      = {{20{prev_data[31]}}, prev_data[7], prev_data[30:25],
                         prev_data[11:8], 1'b0};
    assign fix_target = prev_data[31] ? prev_addr + 32'd4 : prev_addr + b_off;  // opposite of guess

    reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> imem_addr == '0 && !wb_valid && !redirect)
        else begin
            fail_count++;
            $error("core not in its reset state after reset");
        end

    redirect_target: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> imem_addr == $past(fix_target))
        else begin
            fail_count++;
            $error("fetch did not go to the correct branch target");
        end

    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_rd != '0)
        else begin
            fail_count++;
            $error("writeback to x0 was flagged valid");
        end

    redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !redirect)
        else begin
            fail_count++;
            $error("redirect held for two cycles");
        end

endmodule

bind rv_core_top rv_core_assertions u_rv_core_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .redirect  (redirect)
);

// File: bench/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        redirect;

    logic [31:0] mem [64];
    logic [31:0] lfsr_state;
    logic [31:0] end_pc;
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    int          wp;
    int          got_count = 0;
    int          value_errors = 0;
    int          extra_errors = 0;
    int          timeout_errors = 0;
    int          assert_errors;
    int          cyc;

    rv_core_top u_rv_core_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .redirect  (redirect)
    );

    always #5 clk = ~clk;

    // ****************************************
    // program generation
    // ****************************************
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [4:0] r;
        r = 5'(take_bits(3));
        if (r == 5'd0) begin
            r = 5'd7;  // keep to x1..x7
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic sub,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {1'b0, sub, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic place(input logic [31:0] w);
        mem[6'(wp)] = w;
        wp++;
    endtask

    task automatic emit_alu();
        int          sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        sel = int'(take_bits(4) % 32'd10);
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        imm = 12'(take_bits(12));
        case (sel)
            0: place(enc_r(3'b000, 1'b0, rd, rs1, rs2));
            1: place(enc_r(3'b000, 1'b1, rd, rs1, rs2));
            2: place(enc_r(3'b111, 1'b0, rd, rs1, rs2));
            3: place(enc_r(3'b110, 1'b0, rd, rs1, rs2));
            4: place(enc_r(3'b100, 1'b0, rd, rs1, rs2));
            5: place(enc_r(3'b010, 1'b0, rd, rs1, rs2));
            6: place(enc_i(3'b000, rd, rs1, imm));
            7: place(enc_i(3'b111, rd, rs1, imm));
            8: place(enc_i(3'b110, rd, rs1, imm));
            default: place(enc_i(3'b100, rd, rs1, imm));
        endcase
    endtask

    task automatic build_program();
        int         loop_idx;
        logic [2:0] f3;
        logic [4:0] ra;
        logic [4:0] rb;
        for (int i = 0; i < 64; i++) begin
            mem[i] = enc_i(3'b000, 5'd0, 5'd0, 12'(i * 4));  // harmless filler tagged with its address
        end
        wp = 0;
        for (int r = 1; r < 8; r++) begin
            place(enc_i(3'b000, 5'(r), 5'd0, 12'(take_bits(12))));
        end
        place(enc_i(3'b000, 5'd1, 5'd1, 12'd5));  // back to back dependent chain
        place(enc_r(3'b000, 1'b0, 5'd2, 5'd1, 5'd1));
        place(enc_r(3'b000, 1'b1, 5'd3, 5'd2, 5'd1));
        place(enc_b(3'b000, 5'd1, 5'd1, 13'd8));  // always taken so it skips one
        emit_alu();
        place(enc_b(3'b001, 5'd1, 5'd1, 13'd8));  // never taken
        emit_alu();
        for (int i = 0; i < 12; i++) begin
            if (take_bits(2) == 32'd0) begin
                f3 = (take_bits(1) == 32'd1) ? 3'b001 : 3'b000;
                ra = pick_reg();
                rb = pick_reg();
                place(enc_b(f3, ra, rb, 13'd8));
            end
            emit_alu();
        end
        // loop on x8 that runs twice and mispredicts on its exit
        place(enc_i(3'b000, 5'd8, 5'd0, 12'd2));
        loop_idx = wp;
        emit_alu();
        emit_alu();
        place(enc_i(3'b000, 5'd8, 5'd8, 12'hfff));
        place(enc_b(3'b001, 5'd8, 5'd0, 13'((loop_idx - wp) * 4)));
        for (int i = 0; i < 4; i++) begin
            emit_alu();
        end
        end_pc = 32'(wp * 4);
        place(rv_pkg::nop_inst);
        place(enc_b(3'b000, 5'd0, 5'd0, 13'h1ffc));  // parks the core on a predicted loop
    endtask

    // ****************************************
    // reference interpreter
    // ****************************************
    task automatic run_reference();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [4:0]  rd;
        logic        cond;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc = '0;
        steps = 0;
        while (pc != end_pc && steps < 2000) begin
            inst = mem[pc[7:2]];
            rd   = inst[11:7];
            a    = x[inst[19:15]];
            b    = (inst[6:0] == 7'h13) ? {{20{inst[31]}}, inst[31:20]} : x[inst[24:20]];
            case (inst[14:12])
                3'b000:  res = (inst[6:0] == 7'h33 && inst[30]) ? a - b : a + b;
                3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b100:  res = a ^ b;
                3'b110:  res = a | b;
                default: res = a & b;
            endcase
            if (inst[6:0] == 7'h63) begin
                cond = (inst[14:12] == 3'b001) ? (a != b) : (a == b);
                pc = cond ? pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0}
                          : pc + 32'd4;
            end else begin
                if (rd != 5'd0) begin
                    x[rd] = res;
                    exp_rd.push_back(rd);
                    exp_data.push_back(res);
                end
                pc = pc + 32'd4;
            end
            steps++;
        end
    endtask

    // instruction memory answers a little after each rising edge
    initial begin
        imem_data = '0;
        forever begin
            @(posedge clk);
            #1;
            imem_data = mem[imem_addr[7:2]];
        end
    end

    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            assert (got_count < exp_rd.size()) else begin
                extra_errors++;
                $display("unexpected write to x%0d after all %0d expected writes", wb_rd,
                         exp_rd.size());
            end
            if (got_count < exp_rd.size()) begin
                assert (wb_rd == exp_rd[got_count]) else begin
                    value_errors++;
                    $display("Error wb_rd[%0d]: expected %0d, actual %0d", got_count,
                             exp_rd[got_count], wb_rd);
                end
                assert (wb_data == exp_data[got_count]) else begin
                    value_errors++;
                    $display("Error wb_data[%0d]: expected %h, actual %h", got_count,
                             exp_data[got_count], wb_data);
                end
            end
            got_count++;
        end
    end

    initial begin
        rst_n = 1'b0;
        lfsr_state = 32'h6822bae3;
        build_program();
        run_reference();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (cyc = 0; cyc < 1000 && got_count < exp_rd.size(); cyc++) begin
            @(posedge clk);
        end
        if (got_count < exp_rd.size()) begin
            timeout_errors++;
            $display("timed out with %0d of %0d writebacks seen", got_count, exp_rd.size());
        end
        for (cyc = 0; cyc < 20; cyc++) begin
            @(posedge clk);  // quiet window for stray writes
        end
        assert_errors = u_rv_core_top.u_rv_core_assertions.fail_count;
        $display("errors: value %0d, extra %0d, timeout %0d, assertion %0d", value_errors,
                 extra_errors, timeout_errors, assert_errors);
        if (value_errors + extra_errors + timeout_errors + assert_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: common/ex_fb_if.sv
`timescale 1ns/1ps

interface ex_fb_if;

    logic                          wb_valid;
    logic [rv_pkg::reg_addr_w-1:0] wb_rd;
    logic [rv_pkg::xlen-1:0]       wb_data;
    logic                          redirect;     // one cycle pulse on a mispredict
    logic [rv_pkg::xlen-1:0]       redirect_pc;

    modport ex (
        output wb_valid, wb_rd, wb_data, redirect, redirect_pc
    );

    modport dec (
        input wb_valid, wb_rd, wb_data, redirect, redirect_pc
    );

endinterface

// File: common/id_ex_if.sv
`timescale 1ns/1ps

interface id_ex_if;

    logic [rv_pkg::xlen-1:0]       pc;
    logic [rv_pkg::xlen-1:0]       data1;
    logic [rv_pkg::xlen-1:0]       data2;
    logic [rv_pkg::xlen-1:0]       imm;
    logic [rv_pkg::reg_addr_w-1:0] rd;
    logic [rv_pkg::reg_addr_w-1:0] rs1;
    logic [rv_pkg::reg_addr_w-1:0] rs2;
    logic                          predict_taken;
    rv_pkg::ex_ctrl_t              ex_ctrl;
    rv_pkg::wb_ctrl_t              wb_ctrl;
    logic                          valid;  // low marks a bubble

    // producer side of one decoded instruction
    modport src (
        output pc, data1, data2, imm,
        output rd, rs1, rs2,
        output predict_taken, ex_ctrl, wb_ctrl, valid
    );

    modport dst (
        input pc, data1, data2, imm,
        input rd, rs1, rs2,
        input predict_taken, ex_ctrl, wb_ctrl, valid
    );

endinterface

// File: common/rv_pkg.sv
package rv_pkg;

    // ****************************************
    // widths
    // ****************************************
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;  // addi x0, x0, 0

    // ****************************************
    // encodings
    // ****************************************
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,  // register-register
        opc_op_imm = 7'b0010011,
        opc_branch = 7'b1100011
    } opcode_e;

    // funct3 values shared by op and op_imm
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 values for conditional branches
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    localparam int f7_sub_bit = 30;  // inst bit that turns add into sub

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    // ****************************************
    // control fields carried down the pipe
    // ****************************************
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;    // second operand comes from imm
        logic    is_branch;
        logic    branch_ne;  // bne when set, beq otherwise
    } ex_ctrl_t;

    typedef struct packed {
        logic reg_write;
    } wb_ctrl_t;

endpackage

// File: decode/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    input  logic [rv_pkg::xlen-1:0] imem_data,
    ex_fb_if.dec                    fb,
    id_ex_if.src                    out
);

    logic [rv_pkg::xlen-1:0]       pc;
    logic [rv_pkg::xlen-1:0]       next_pc;
    logic [rv_pkg::xlen-1:0]       inst;
    logic [rv_pkg::xlen-1:0]       imm_i;
    logic [rv_pkg::xlen-1:0]       imm_b;
    logic [rv_pkg::xlen-1:0]       rd1;
    logic [rv_pkg::xlen-1:0]       rd2;
    logic [rv_pkg::reg_addr_w-1:0] rs1;
    logic [rv_pkg::reg_addr_w-1:0] rs2;
    logic [rv_pkg::reg_addr_w-1:0] rd;
    logic [2:0]                    funct3;
    rv_pkg::opcode_e               opcode;
    rv_pkg::ex_ctrl_t              ex_ctrl;
    logic                          reg_write;
    logic                          known;
    logic                          predict_taken;

    // ****************************************
    // fetch
    // ****************************************
    assign imem_addr = pc;
    assign next_pc   = predict_taken ? pc + imm_b : pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= fb.redirect ? fb.redirect_pc : next_pc;  // execute wins over prediction
        end
    end

    assign inst = imem_data;

    // ****************************************
    // field extraction
    // ****************************************
    assign opcode = rv_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    reg_file u_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (rs1),
        .ra2   (rs2),
        .rd1   (rd1),
        .rd2   (rd2),
        .we    (fb.wb_valid),
        .wa    (fb.wb_rd),
        .wd    (fb.wb_data)
    );

    // ****************************************
    // decode and prediction
    // ****************************************
    always_comb begin
        ex_ctrl       = '0;
        reg_write     = 1'b0;
        known         = 1'b0;
        predict_taken = 1'b0;
        case (opcode)
            rv_pkg::opc_op, rv_pkg::opc_op_imm: begin
                known     = 1'b1;
                reg_write = 1'b1;
                ex_ctrl.use_imm = (opcode == rv_pkg::opc_op_imm);
                case (funct3)
                    rv_pkg::f3_add_sub: begin
                        // only the register form has a sub
                        if (inst[rv_pkg::f7_sub_bit] && !ex_ctrl.use_imm) begin
                            ex_ctrl.alu_op = rv_pkg::alu_sub;
                        end else begin
                            ex_ctrl.alu_op = rv_pkg::alu_add;
                        end
                    end
                    rv_pkg::f3_and: ex_ctrl.alu_op = rv_pkg::alu_and;
                    rv_pkg::f3_or:  ex_ctrl.alu_op = rv_pkg::alu_or;
                    rv_pkg::f3_xor: ex_ctrl.alu_op = rv_pkg::alu_xor;
                    rv_pkg::f3_slt: begin
                        ex_ctrl.alu_op = rv_pkg::alu_slt;
                        known = !ex_ctrl.use_imm;  // slti is not supported
                    end
                    default: known = 1'b0;
                endcase
            end
            rv_pkg::opc_branch: begin
                ex_ctrl.is_branch = 1'b1;
                ex_ctrl.branch_ne = (funct3 == rv_pkg::f3_bne);
                known = (funct3 == rv_pkg::f3_beq) || (funct3 == rv_pkg::f3_bne);
                predict_taken = known && inst[31];  // backward taken and forward not taken
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        out.pc            = pc;
        out.imm           = ex_ctrl.is_branch ? imm_b : imm_i;
        out.rs1           = rs1;
        out.rs2           = ex_ctrl.use_imm ? '0 : rs2;
        out.rd            = ex_ctrl.is_branch ? '0 : rd;
        // the register file is written at the end of this cycle so pass the value through
        out.data1         = (fb.wb_valid && fb.wb_rd == rs1) ? fb.wb_data : rd1;
        out.data2         = (fb.wb_valid && fb.wb_rd == rs2) ? fb.wb_data : rd2;
        out.predict_taken = predict_taken;
        out.ex_ctrl       = known ? ex_ctrl : '0;
        out.wb_ctrl       = '{reg_write: known && reg_write};
        out.valid         = known;
    end

endmodule

// File: decode/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::reg_addr_w-1:0] ra1,
    input  logic [rv_pkg::reg_addr_w-1:0] ra2,
    output logic [rv_pkg::xlen-1:0]       rd1,
    output logic [rv_pkg::xlen-1:0]       rd2,
    input  logic                          we,
    input  logic [rv_pkg::reg_addr_w-1:0] wa,
    input  logic [rv_pkg::xlen-1:0]       wd
);

    logic [rv_pkg::xlen-1:0] regs [2**rv_pkg::reg_addr_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**rv_pkg::reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin  // x0 stays zero
            regs[wa] <= wd;
        end
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic clk,
    input  logic rst_n,
    id_ex_if.dst in,
    ex_fb_if.ex  fb,
    output logic flush
);

    logic [rv_pkg::xlen-1:0]       op_a;
    logic [rv_pkg::xlen-1:0]       op_b;
    logic [rv_pkg::xlen-1:0]       src_b;
    logic [rv_pkg::xlen-1:0]       alu_res;
    logic                          taken;
    logic                          mispredict;
    logic                          wb_valid_q;
    logic [rv_pkg::reg_addr_w-1:0] wb_rd_q;
    logic [rv_pkg::xlen-1:0]       wb_data_q;

    // ****************************************
    // forwarding from the writeback register
    // ****************************************
    // wb_rd_q is never x0 while wb_valid_q is set
    assign op_a  = (wb_valid_q && wb_rd_q == in.rs1) ? wb_data_q : in.data1;
    assign op_b  = (wb_valid_q && wb_rd_q == in.rs2) ? wb_data_q : in.data2;
    assign src_b = in.ex_ctrl.use_imm ? in.imm : op_b;

    always_comb begin
        case (in.ex_ctrl.alu_op)
            rv_pkg::alu_add: alu_res = op_a + src_b;
            rv_pkg::alu_sub: alu_res = op_a - src_b;
            rv_pkg::alu_and: alu_res = op_a & src_b;
            rv_pkg::alu_or:  alu_res = op_a | src_b;
            rv_pkg::alu_xor: alu_res = op_a ^ src_b;
            rv_pkg::alu_slt: alu_res = {31'd0, $signed(op_a) < $signed(src_b)};
            default:         alu_res = '0;
        endcase
    end

    // ****************************************
    // branch resolution
    // ****************************************
    assign taken      = in.ex_ctrl.branch_ne ? (op_a != op_b) : (op_a == op_b);
    assign mispredict = in.valid && in.ex_ctrl.is_branch && (taken != in.predict_taken);

    assign fb.redirect    = mispredict;
    assign fb.redirect_pc = taken ? in.pc + in.imm : in.pc + 32'd4;
    assign flush          = mispredict;  // kills the wrong-path instruction in decode

    // ****************************************
    // writeback register
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= in.valid && in.wb_ctrl.reg_write && in.rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_q   <= in.rd;
        wb_data_q <= alu_res;
    end

    assign fb.wb_valid = wb_valid_q;
    assign fb.wb_rd    = wb_rd_q;
    assign fb.wb_data  = wb_data_q;

endmodule

// File: hdl/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,  // control hazard, turns the captured slot into a bubble
    id_ex_if.dst in,
    id_ex_if.src out
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.pc            <= '0;
            out.data1         <= '0;
            out.data2         <= '0;
            out.imm           <= '0;
            out.rd            <= '0;
            out.rs1           <= '0;
            out.rs2           <= '0;
            out.predict_taken <= 1'b0;
            out.ex_ctrl       <= '0;
            out.wb_ctrl       <= '0;
            out.valid         <= 1'b0;
        end else if (flush) begin
            out.pc            <= '0;
            out.data1         <= '0;
            out.data2         <= '0;
            out.imm           <= '0;
            out.rd            <= '0;
            out.rs1           <= '0;
            out.rs2           <= '0;
            out.predict_taken <= 1'b0;
            out.ex_ctrl       <= '0;
            out.wb_ctrl       <= '0;
            out.valid         <= 1'b0;
        end else begin
            out.pc            <= in.pc;
            out.data1         <= in.data1;
            out.data2         <= in.data2;
            out.imm           <= in.imm;
            out.rd            <= in.rd;
            out.rs1           <= in.rs1;
            out.rs2           <= in.rs2;
            out.predict_taken <= in.predict_taken;
            out.ex_ctrl       <= in.ex_ctrl;
            out.wb_ctrl       <= in.wb_ctrl;
            out.valid         <= in.valid;
        end
    end

endmodule

// File: hdl/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic [rv_pkg::xlen-1:0]       imem_addr,
    input  logic [rv_pkg::xlen-1:0]       imem_data,
    output logic                          wb_valid,
    output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_pkg::xlen-1:0]       wb_data,
    output logic                          redirect
);

    logic flush;

    id_ex_if dec_if ();  // decode into the pipeline register
    id_ex_if ex_if ();   // pipeline register into execute
    ex_fb_if fb_if ();

    decode_stage u_decode_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .fb        (fb_if.dec),
        .out       (dec_if.src)
    );

    id_ex_reg u_id_ex_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .in    (dec_if.dst),
        .out   (ex_if.src)
    );

    execute_stage u_execute_stage (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (ex_if.dst),
        .fb    (fb_if.ex),
        .flush (flush)
    );

    assign wb_valid = fb_if.wb_valid;
    assign wb_rd    = fb_if.wb_rd;
    assign wb_data  = fb_if.wb_data;
    assign redirect = fb_if.redirect;

endmodule

// File: list.f
common/rv_pkg.sv
common/id_ex_if.sv
common/ex_fb_if.sv
decode/reg_file.sv
decode/decode_stage.sv
hdl/id_ex_reg.sv
hdl/execute_stage.sv
hdl/rv_core_top.sv
bench/rv_core_assertions.sv
bench/rv_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/rv_core_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0
